// ==== dv/program_input.txt ====
# program words in hex, one per line from address 0, then a line starting with --
# after it, expected register writes in retire order: test number, rd (decimal), value (hex)
# test 1: independent alu operations
06400093    # 00 addi x1, x0, 100
ff900113    # 04 addi x2, x0, -7
123451b7    # 08 lui  x3, 0x12345
5a500213    # 0c addi x4, x0, 0x5a5
002082b3    # 10 add  x5, x1, x2
40208333    # 14 sub  x6, x1, x2
004173b3    # 18 and  x7, x2, x4
0041e433    # 1c or   x8, x3, x4
0040c4b3    # 20 xor  x9, x1, x4
# test 2: dependences at distance 1 to 4
00100513    # 24 addi x10, x0, 1
00250513    # 28 addi x10, x10, 2
01000593    # 2c addi x11, x0, 16
02000613    # 30 addi x12, x0, 32
00a586b3    # 34 add  x13, x11, x10
00500713    # 38 addi x14, x0, 5
04000813    # 3c addi x16, x0, 64
40e607b3    # 40 sub  x15, x12, x14
# test 3: writes to x0 and reads of x0
03708013    # 44 addi x0, x1, 55
00208033    # 48 add  x0, x1, x2
00900893    # 4c addi x17, x0, 9
00006933    # 50 or   x18, x0, x0
# test 4: taken and not-taken branches
00108663    # 54 beq  x1, x1, +12
00100993    # 58 addi x19, x0, 1 (skipped)
00200993    # 5c addi x19, x0, 2 (skipped)
00300a13    # 60 addi x20, x0, 3
00209663    # 64 bne  x1, x2, +12
00400993    # 68 addi x19, x0, 4 (skipped)
00500993    # 6c addi x19, x0, 5 (skipped)
00208663    # 70 beq  x1, x2, +12 (not taken)
00600a93    # 74 addi x21, x0, 6
00109663    # 78 bne  x1, x1, +12 (not taken)
00700b13    # 7c addi x22, x0, 7
00800b93    # 80 addi x23, x0, 8
# test 5: jal
01000c6f    # 84 jal  x24, +16
00900993    # 88 addi x19, x0, 9 (skipped)
00a00993    # 8c addi x19, x0, 10 (skipped)
00b00993    # 90 addi x19, x0, 11 (skipped)
004c0c93    # 94 addi x25, x24, 4
00800d6f    # 98 jal  x26, +8
00c00993    # 9c addi x19, x0, 12 (skipped)
01ac8db3    # a0 add  x27, x25, x26
-- expected writes
1 1 00000064
1 2 fffffff9
1 3 12345000
1 4 000005a5
1 5 0000005d
1 6 0000006b
1 7 000005a1
1 8 123455a5
1 9 000005c1
2 10 00000001
2 10 00000003
2 11 00000010
2 12 00000020
2 13 00000013
2 14 00000005
2 16 00000040
2 15 0000001b
3 17 00000009
3 18 00000000
4 20 00000003
4 21 00000006
4 22 00000007
4 23 00000008
5 24 00000088
5 25 0000008c
5 26 0000009c
5 27 00000128

// ==== dv/tb_rv5_core.sv ====
// testbench of the rv5 core, runs the program from the data file and checks every retired write
`default_nettype none

module tb_rv5_core import rv5_pkg::*; ();

    localparam int          MEM_WORDS   = 4096;
    localparam int          MAX_EXP     = 128;
    localparam int          WAIT_LIMIT  = 2000;
    localparam int          TAIL_CYCLES = 50;
    localparam int          TAIL_TEST   = 6;
    localparam logic [31:0] RNG_SEED    = 32'h5303_86ec;
    localparam logic [31:0] NOP_ADDI    = 32'h0000_0013;
    localparam logic [31:0] RESET_PC    = 32'h0000_0000;
    localparam string       INPUT_FILE  = "dv/program_input.txt";

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    wb_rec_s     retire;

    logic [31:0] prog_mem [MEM_WORDS];
    int          prog_words;
    int          exp_test [MAX_EXP];
    logic [4:0]  exp_rd   [MAX_EXP];
    logic [31:0] exp_val  [MAX_EXP];
    int          exp_count;
    int          exp_idx;
    int          test_checks [TAIL_TEST + 1];
    int          test_errors [TAIL_TEST + 1];
    int          errors;

    rv5_core u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory answers in the same cycle
    always_comb begin
        if (imem_addr < 32'(MEM_WORDS * 4)) begin
            imem_data = prog_mem[imem_addr[13:2]];
        end else begin
            imem_data = NOP_ADDI;
        end
    end

    // encodings that write nothing, used past the end of the program
    function automatic logic [31:0] pick_nop(input int unsigned sel);
        case (sel % 4)
            0:       return 32'h0000_0013;  // addi x0, x0, 0
            1:       return 32'h0000_0033;  // add x0, x0, x0
            2:       return 32'h0000_4033;  // xor x0, x0, x0
            default: return 32'h0000_6013;  // ori x0, x0, 0
        endcase
    endfunction

    function automatic string test_label(input int t);
        case (t)
            1:       return "alu_ops";
            2:       return "dependences";
            3:       return "x0_writes";
            4:       return "branches";
            5:       return "jal";
            6:       return "tail_quiet";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_input();
        int          fd;
        int          i;
        int          t;
        int          rd;
        logic [31:0] word;
        logic [31:0] val;
        string       line;
        bit          in_expect;
        for (i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] = pick_nop($urandom);
        end
        in_expect = 1'b0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the program file %s", INPUT_FILE);
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (line.getc(0) == "-") begin
                in_expect = 1'b1;
            end else if (!in_expect) begin
                if ($sscanf(line, "%h", word) == 1 && prog_words < MEM_WORDS) begin
                    prog_mem[prog_words] = word;
                    prog_words++;
                end
            end else if ($sscanf(line, "%d %d %h", t, rd, val) == 3) begin
                if (t < 1 || t >= TAIL_TEST || exp_count >= MAX_EXP) begin
                    $display("ERROR: expected record with test %0d and rd %0d is not usable",
                             t, rd);
                    errors++;
                end else begin
                    exp_test[exp_count] = t;
                    exp_rd[exp_count]   = 5'(rd);
                    exp_val[exp_count]  = val;
                    exp_count++;
                end
            end
        end
        $fclose(fd);
        if (prog_words == 0 || exp_count == 0) begin
            $display("ERROR: the program file holds no program or no expected writes");
            errors++;
        end
        $display("loaded %0d program words and %0d expected writes", prog_words, exp_count);
    endtask

    task automatic report_test(input int t);
        $display("test %s done: %0d checks, %0d errors", test_label(t), test_checks[t],
                 test_errors[t]);
    endtask

    // first fetch address and an empty retire port once reset is released
    task automatic compare_reset_state();
        int fails;
        fails = 0;
        if (imem_addr !== RESET_PC) begin
            $display("FAIL reset_state: expected imem_addr = %08h, actual imem_addr = %08h",
                     RESET_PC, imem_addr);
            fails++;
        end
        if (retire.valid !== 1'b0) begin
            $display("FAIL reset_state: expected retire valid = 0, actual retire valid = %b",
                     retire.valid);
            fails++;
        end
        errors += fails;
        $display("test reset_state done: 2 checks, %0d errors", fails);
    endtask

    // only write records are compared, branches and x0 targets retire without one
    task automatic check_retire();
        int t;
        if (retire.valid && retire.we) begin
            t = (exp_idx < exp_count) ? exp_test[exp_idx] : TAIL_TEST;
            if (retire.rd == 5'd0) begin
                $display("ERROR: a write to x0 reached the retire port in test %s",
                         test_label(t));
                test_errors[t]++;
                errors++;
            end else if (exp_idx >= exp_count) begin
                $display("ERROR: x%0d was written with %08h after the last expected write",
                         retire.rd, retire.result);
                test_errors[t]++;
                errors++;
            end else begin
                test_checks[t]++;
                if (retire.rd != exp_rd[exp_idx] || retire.result != exp_val[exp_idx]) begin
                    $display("FAIL %s: expected x%0d = %08h, actual x%0d = %08h",
                             test_label(t), exp_rd[exp_idx], exp_val[exp_idx],
                             retire.rd, retire.result);
                    test_errors[t]++;
                    errors++;
                end
                exp_idx++;
                // last record of this section
                if (exp_idx == exp_count || exp_test[exp_idx] != t) begin
                    report_test(t);
                end
            end
        end
    endtask

    initial begin
        int cycles;
        rst_n      = 1'b0;
        errors     = 0;
        prog_words = 0;
        exp_count  = 0;
        exp_idx    = 0;
        for (int t = 0; t <= TAIL_TEST; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        void'($urandom(RNG_SEED));
        load_input();

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // nothing has been fetched past the reset vector yet
        @(negedge clk);
        compare_reset_state();

        // retire records sampled mid-cycle
        cycles = 0;
        while (exp_idx < exp_count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            check_retire();
            cycles++;
        end

        if (exp_idx < exp_count) begin
            $display("timeout: only %0d of %0d expected writes retired within %0d cycles",
                     exp_idx, exp_count, WAIT_LIMIT);
            errors++;
        end else begin
            // core now runs through non-writing words
            cycles = 0;
            while (cycles < TAIL_CYCLES) begin
                @(negedge clk);
                check_retire();
                test_checks[TAIL_TEST]++;
                cycles++;
            end
            report_test(TAIL_TEST);
        end

        $display("summary: %0d of %0d expected writes checked, %0d errors", exp_idx,
                 exp_count, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rv5 core testbench with Verilator, runs it and scans the log for the verdict

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module tb_rv5_core -f rv5_pipe.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_rv5_core > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error status"
    exit 1
fi
cat "$log"

if grep -q "TESTS FAILED" "$log"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
    echo "simulation log holds no verdict"
    exit 1
fi
exit 0

// ==== rv5_pipe.f ====
+incdir+src
src/rv5_pkg.sv
src/hazard_unit.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/retire_pipe.sv
src/rv5_core.sv
dv/tb_rv5_core.sv

// ==== src/decode_stage.sv ====
// instruction decode of the rv5 pipeline, producing the record that execute consumes
`default_nettype none

`include "rv5_cfg.svh"

module decode_stage import rv5_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  instr_u      if_instr,
    input  logic [31:0] if_pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    input  logic        dec_kill,
    output dec_exe_s    dec_exe,
    output fwd_dst_s    dec_dst
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        supported;
    logic        writes_rd;
    dec_exe_s    dec_d;

    // immediates rebuilt from the i_fmt view
    assign imm_i = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
    assign imm_u = {if_instr.i_fmt.imm, if_instr.i_fmt.rs1, if_instr.i_fmt.funct3, 12'd0};
    assign imm_b = {{20{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.rd[0],
                    if_instr.i_fmt.imm[10:5], if_instr.i_fmt.rd[4:1], 1'b0};
    assign imm_j = {{12{if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.rs1, if_instr.i_fmt.funct3,
                    if_instr.i_fmt.imm[0], if_instr.i_fmt.imm[10:1], 1'b0};

    always_comb begin
        dec_d         = '0;
        dec_d.pc      = if_pc;
        dec_d.op_a    = rs1_data;
        dec_d.op_b    = rs2_data;
        dec_d.rs2_val = rs2_data;
        dec_d.alu_op  = ALU_ADD;
        dec_d.br_kind = BR_NONE;
        dec_d.rd      = if_instr.r_fmt.rd;
        supported     = 1'b1;
        writes_rd     = 1'b0;
        case (if_instr.r_fmt.opcode)
            OPC_OP: begin
                writes_rd = 1'b1;
                // only bit 5 of funct7 is legal, it selects sub
                if ((if_instr.r_fmt.funct7 & 7'b1011111) != 7'd0) begin
                    supported = 1'b0;
                end
                case (if_instr.r_fmt.funct3)
                    3'b000:  dec_d.alu_op = if_instr.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b100:  dec_d.alu_op = ALU_XOR;
                    3'b110:  dec_d.alu_op = ALU_OR;
                    3'b111:  dec_d.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                writes_rd  = 1'b1;
                dec_d.op_b = imm_i;
                supported  = (if_instr.i_fmt.funct3 == 3'b000);
            end
            OPC_LUI: begin
                writes_rd    = 1'b1;
                dec_d.op_b   = imm_u;
                dec_d.alu_op = ALU_PASS_B;
            end
            OPC_BRANCH: begin
                dec_d.op_b = imm_b;
                case (if_instr.i_fmt.funct3)
                    3'b000:  dec_d.br_kind = BR_EQ;
                    3'b001:  dec_d.br_kind = BR_NE;
                    default: supported = 1'b0;
                endcase
            end
            OPC_JAL: begin
                writes_rd     = 1'b1;
                dec_d.op_b    = imm_j;
                dec_d.br_kind = BR_JAL;
            end
            default: supported = 1'b0;
        endcase
        dec_d.we    = writes_rd && (dec_d.rd != 5'd0);
        dec_d.valid = supported && (if_instr != `RV5_NOP);
    end

    assign dec_dst.rd = dec_d.rd;
    assign dec_dst.we = dec_d.valid && dec_d.we;

    always_ff @(posedge clk) begin
        dec_exe <= dec_d;
        if (!rst_n || dec_kill) begin
            dec_exe.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// ALU and branch resolution of the rv5 pipeline, registering the memory stage record
`default_nettype none

module execute_stage import rv5_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  dec_exe_s    dec_exe,
    output logic        branch_taken,
    output logic [31:0] branch_target,
    output fwd_dst_s    exe_dst,
    output wb_rec_s     exe_res
);

    logic [31:0] alu_res;
    logic        operands_eq;
    wb_rec_s     exe_d;

    always_comb begin
        case (dec_exe.alu_op)
            ALU_ADD:    alu_res = dec_exe.op_a + dec_exe.op_b;
            ALU_SUB:    alu_res = dec_exe.op_a - dec_exe.op_b;
            ALU_AND:    alu_res = dec_exe.op_a & dec_exe.op_b;
            ALU_OR:     alu_res = dec_exe.op_a | dec_exe.op_b;
            ALU_XOR:    alu_res = dec_exe.op_a ^ dec_exe.op_b;
            ALU_PASS_B: alu_res = dec_exe.op_b;
            default:    alu_res = dec_exe.op_a + dec_exe.op_b;
        endcase
    end

    // branch compare uses rs2 directly, op_b holds the offset
    assign operands_eq = (dec_exe.op_a == dec_exe.rs2_val);

    always_comb begin
        case (dec_exe.br_kind)
            BR_EQ:   branch_taken = dec_exe.valid && operands_eq;
            BR_NE:   branch_taken = dec_exe.valid && !operands_eq;
            BR_JAL:  branch_taken = dec_exe.valid;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = dec_exe.pc + dec_exe.op_b;

    assign exe_dst.rd = dec_exe.rd;
    assign exe_dst.we = dec_exe.valid && dec_exe.we;

    // the branch record itself moves on, only jal carries a write
    always_comb begin
        exe_d.valid  = dec_exe.valid;
        exe_d.rd     = dec_exe.rd;
        exe_d.we     = dec_exe.we;
        exe_d.result = (dec_exe.br_kind == BR_JAL) ? (dec_exe.pc + 32'd4) : alu_res;
    end

    // execute-to-memory register
    always_ff @(posedge clk) begin
        exe_res <= exe_d;
        if (!rst_n) begin
            exe_res.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
// program counter and fetch-to-decode register of the rv5 pipeline, driving the imem address
`default_nettype none

`include "rv5_cfg.svh"

module fetch_stage import rv5_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_write_en,
    input  logic        if_kill,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output logic [4:0]  if_rs1,
    output logic [4:0]  if_rs2,
    output instr_u      if_instr,
    output logic [31:0] if_pc
);

    logic [31:0] pc;
    instr_u      fetch_word;

    // imem answers in the same cycle
    assign imem_addr  = pc;
    assign fetch_word = imem_data;

    // source fields go straight to the register file and hazard unit
    assign if_rs1 = fetch_word.r_fmt.rs1;
    assign if_rs2 = fetch_word.r_fmt.rs2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RV5_RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (pc_write_en) begin
            pc <= pc + 32'd4;
        end
    end

    // a killed slot becomes a nop, which decode reads as invalid
    always_ff @(posedge clk) begin
        if_pc <= pc;
        if (!rst_n || if_kill) begin
            if_instr <= `RV5_NOP;
        end else begin
            if_instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
// stall and flush control of the rv5 pipeline, fed with the destination of every later stage
`default_nettype none

module hazard_unit import rv5_pkg::*; (
    input  logic [4:0] if_rs1,
    input  logic [4:0] if_rs2,
    input  fwd_dst_s   dec_dst,
    input  fwd_dst_s   exe_dst,
    input  fwd_dst_s   mem_dst,
    input  fwd_dst_s   wb_dst,
    input  logic       branch_taken,
    output logic       pc_write_en,
    output logic       if_kill,
    output logic       dec_kill
);

    logic [3:0] dst_match;
    logic       raw_stall;

    // x0 never carries a dependence
    function automatic logic dst_hit(input fwd_dst_s dst, input logic [4:0] rs_a,
                                     input logic [4:0] rs_b);
        return dst.we && (dst.rd != 5'd0) && ((dst.rd == rs_a) || (dst.rd == rs_b));
    endfunction

    // no forwarding, so any pending writer up to writeback holds the fetch
    assign dst_match[0] = dst_hit(dec_dst, if_rs1, if_rs2);
    assign dst_match[1] = dst_hit(exe_dst, if_rs1, if_rs2);
    assign dst_match[2] = dst_hit(mem_dst, if_rs1, if_rs2);
    assign dst_match[3] = dst_hit(wb_dst, if_rs1, if_rs2);
    assign raw_stall    = |dst_match;

    always_comb begin
        if (branch_taken) begin
            // redirect, drop both younger instructions
            pc_write_en = 1'b1;
            if_kill     = 1'b1;
            dec_kill    = 1'b1;
        end else if (raw_stall) begin
            // hold pc, feed a bubble into decode
            pc_write_en = 1'b0;
            if_kill     = 1'b1;
            dec_kill    = 1'b0;
        end else begin
            pc_write_en = 1'b1;
            if_kill     = 1'b0;
            dec_kill    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// integer register file of the rv5 pipeline, read from fetch and written from writeback
`default_nettype none

`include "rv5_cfg.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  if_rs1,
    input  logic [4:0]  if_rs2,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [`RV5_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read data lands in decode at the same edge as the instruction
    // no write-through, the hazard unit waits until writeback is done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rs1_data <= 32'd0;
            rs2_data <= 32'd0;
        end else begin
            rs1_data <= (if_rs1 == 5'd0) ? 32'd0 : regs[if_rs1];
            rs2_data <= (if_rs2 == 5'd0) ? 32'd0 : regs[if_rs2];
        end
    end

    // retire strobe must already exclude x0
    assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> (wr_addr != 5'd0))
        else $error("reg_file: write strobe addressed to x0");

endmodule

`default_nettype wire

// ==== src/retire_pipe.sv ====
// memory and writeback stages of the rv5 pipeline, producing the register write and retire record
`default_nettype none

module retire_pipe import rv5_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  wb_rec_s     exe_res,
    output fwd_dst_s    mem_dst,
    output fwd_dst_s    wb_dst,
    output logic        rf_wr_en,
    output logic [4:0]  rf_wr_addr,
    output logic [31:0] rf_wr_data,
    output wb_rec_s     retire
);

    wb_rec_s wb_q;

    // memory stage has no data access, its record arrives registered from execute
    assign mem_dst.rd = exe_res.rd;
    assign mem_dst.we = exe_res.valid && exe_res.we;

    // memory-to-writeback register
    always_ff @(posedge clk) begin
        wb_q <= exe_res;
        if (!rst_n) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign wb_dst.rd = wb_q.rd;
    assign wb_dst.we = wb_q.valid && wb_q.we;

    // x0 is filtered here so the file never sees it
    assign rf_wr_en   = wb_q.valid && wb_q.we && (wb_q.rd != 5'd0);
    assign rf_wr_addr = wb_q.rd;
    assign rf_wr_data = wb_q.result;

    assign retire = wb_q;

endmodule

`default_nettype wire

// ==== src/rv5_cfg.svh ====
// reset vector, register count and bubble encoding, included by the rv5 RTL that needs them
`ifndef RV5_CFG_SVH
`define RV5_CFG_SVH

// address of the first fetch after reset
`define RV5_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define RV5_NUM_REGS 32

// addi x0, x0, 0
// a slot holding exactly this word is treated as a bubble
`define RV5_NOP 32'h0000_0013

`endif

// ==== src/rv5_core.sv ====
// top of the rv5 five-stage core, connecting stages, hazard unit and register file
`default_nettype none

module rv5_core import rv5_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    output wb_rec_s     retire
);

    logic        pc_write_en;
    logic        if_kill;
    logic        dec_kill;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [4:0]  if_rs1;
    logic [4:0]  if_rs2;
    instr_u      if_instr;
    logic [31:0] if_pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    dec_exe_s    dec_exe;
    fwd_dst_s    dec_dst;
    fwd_dst_s    exe_dst;
    fwd_dst_s    mem_dst;
    fwd_dst_s    wb_dst;
    wb_rec_s     exe_res;
    logic        rf_wr_en;
    logic [4:0]  rf_wr_addr;
    logic [31:0] rf_wr_data;

    hazard_unit u_hazard (
        .if_rs1       (if_rs1),
        .if_rs2       (if_rs2),
        .dec_dst      (dec_dst),
        .exe_dst      (exe_dst),
        .mem_dst      (mem_dst),
        .wb_dst       (wb_dst),
        .branch_taken (branch_taken),
        .pc_write_en  (pc_write_en),
        .if_kill      (if_kill),
        .dec_kill     (dec_kill)
    );

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_write_en   (pc_write_en),
        .if_kill       (if_kill),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .imem_addr     (imem_addr),
        .imem_data     (imem_data),
        .if_rs1        (if_rs1),
        .if_rs2        (if_rs2),
        .if_instr      (if_instr),
        .if_pc         (if_pc)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_rs1   (if_rs1),
        .if_rs2   (if_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (rf_wr_en),
        .wr_addr  (rf_wr_addr),
        .wr_data  (rf_wr_data)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_instr (if_instr),
        .if_pc    (if_pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec_kill (dec_kill),
        .dec_exe  (dec_exe),
        .dec_dst  (dec_dst)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_exe       (dec_exe),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exe_dst       (exe_dst),
        .exe_res       (exe_res)
    );

    retire_pipe u_retire (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_res    (exe_res),
        .mem_dst    (mem_dst),
        .wb_dst     (wb_dst),
        .rf_wr_en   (rf_wr_en),
        .rf_wr_addr (rf_wr_addr),
        .rf_wr_data (rf_wr_data),
        .retire     (retire)
    );

endmodule

`default_nettype wire

// ==== src/rv5_pkg.sv ====
// shared types of the rv5 pipeline, imported by each stage that passes records or decodes words
`default_nettype none

package rv5_pkg;

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_s;

    // immediate layout, also the source of the B and J bit scatter
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_s;

    typedef union packed {
        instr_r_s r_fmt;
        instr_i_s i_fmt;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } br_kind_e;

    // decode to execute record
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] rs2_val;
        alu_op_e     alu_op;
        br_kind_e    br_kind;
        logic [4:0]  rd;
        logic        we;
    } dec_exe_s;

    // result record from execute through writeback, also the retire port
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        we;
        logic [31:0] result;
    } wb_rec_s;

    // destination a stage reports to the hazard unit, we already qualified by valid
    typedef struct packed {
        logic [4:0] rd;
        logic       we;
    } fwd_dst_s;

endpackage

`default_nettype wire
